//--- include/rename_consts.svh
/* Sizes of the rename stage. The free list depth must stay a power of two,
   and one checkpoint slot is always the working copy. */
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// Register files
`define NUM_PHYS_REGS 64  // Physical registers
`define NUM_ISA_REGS 32  // RISC-V integer registers, x0 included

// Registers that can be free at once
`define NUM_FREE_ENTRIES (`NUM_PHYS_REGS - `NUM_ISA_REGS)

// Checkpoint slots, at most NUM_CHECKPOINTS-1 live
`define NUM_CHECKPOINTS 4

// Free dispatch slots behind the rename stage
`define NUM_DISPATCH_CREDITS 4

`endif

//--- list.f
+incdir+include
source/rename_pkg.sv
source/free_list.sv
source/rename_table.sv
source/rename_unit.sv
verif/tb_rename_unit.sv

//--- source/free_list.sv
/* Circular free list with one copy per checkpoint. Commit frees are appended to
   every copy, so a recover never loses a committed register. No push or pop
   happens in a recover cycle. */
`timescale 1ns/10ps
`include "rename_consts.svh"

module free_list (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        alloc_i,              // Pop the head
    input  logic                        free_i,               // Push at the tail
    input  rename_pkg::phreg_t          free_preg_i,
    input  logic                        do_checkpoint_i,      // Copy after this cycle's update
    input  logic                        do_recover_i,
    input  logic                        delete_checkpoint_i,  // Retire oldest live copy
    input  rename_pkg::checkpoint_ptr_t recover_checkpoint_i,
    output rename_pkg::phreg_t          new_preg_o,           // Popped register, next edge
    output rename_pkg::phreg_t          head_preg_o,          // Register a pop would return now
    output rename_pkg::checkpoint_ptr_t checkpoint_o,         // Label of the last checkpoint
    output logic                        out_of_checkpoints_o,
    output logic                        empty_o
);
    import rename_pkg::*;

    typedef logic [$clog2(`NUM_FREE_ENTRIES)-1:0] fl_idx_t;   // Entry index, wraps
    typedef logic [$clog2(`NUM_FREE_ENTRIES):0]   fl_cnt_t;   // 0 to NUM_FREE_ENTRIES
    typedef logic [$bits(checkpoint_ptr_t):0]     ckpt_cnt_t; // Live checkpoints

    // Storage, one copy per checkpoint slot
    phreg_t  fl_table [`NUM_CHECKPOINTS][`NUM_FREE_ENTRIES];
    fl_idx_t head_q   [`NUM_CHECKPOINTS];
    fl_idx_t tail_q   [`NUM_CHECKPOINTS];
    fl_cnt_t count_q  [`NUM_CHECKPOINTS];

    checkpoint_ptr_t version_head_q; // Working copy
    checkpoint_ptr_t version_tail_q; // Oldest live checkpoint
    checkpoint_ptr_t version_next;
    checkpoint_ptr_t vtail_n;
    ckpt_cnt_t       live_q;

    logic    push;       // Accepted free
    logic    pop;        // Accepted allocation
    logic    bypass;     // Empty list, free goes straight out
    logic    work_write; // Free lands in the working table
    logic    ckpt_en;
    fl_idx_t head_n;
    fl_idx_t tail_n;
    fl_cnt_t count_n;

    assign version_next = version_head_q + 1'b1;
    assign vtail_n      = version_tail_q + checkpoint_ptr_t'(delete_checkpoint_i);

    assign empty_o              = (count_q[version_head_q] == '0);
    assign out_of_checkpoints_o = (live_q == ckpt_cnt_t'(`NUM_CHECKPOINTS - 1));

    assign push       = free_i & ~do_recover_i &
                        (count_q[version_head_q] < fl_cnt_t'(`NUM_FREE_ENTRIES));
    assign pop        = alloc_i & ~do_recover_i & (~empty_o | push);
    assign bypass     = pop & empty_o;
    assign work_write = push & ~bypass;
    assign ckpt_en    = do_checkpoint_i & ~out_of_checkpoints_o & ~do_recover_i;

    // Tail to head bypass when nothing is stored
    assign head_preg_o = empty_o ? free_preg_i
                                 : fl_table[version_head_q][head_q[version_head_q]];

    // Working pointers after this cycle, a bypass moves neither
    assign head_n  = head_q[version_head_q] + fl_idx_t'(pop & ~bypass);
    assign tail_n  = tail_q[version_head_q] + fl_idx_t'(work_write);
    assign count_n = count_q[version_head_q] + fl_cnt_t'(work_write)
                     - fl_cnt_t'(pop & ~bypass);

    // Pointers, counts and checkpoint bookkeeping
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int c = 0; c < `NUM_CHECKPOINTS; c++) begin
                head_q[c]  <= '0;
                tail_q[c]  <= '0;
                count_q[c] <= fl_cnt_t'(`NUM_FREE_ENTRIES); // All of 32..63 free
            end
            version_head_q <= '0;
            version_tail_q <= '0;
            live_q         <= '0;
            checkpoint_o   <= '0;
        end else begin
            version_tail_q <= vtail_n;
            if (do_recover_i) begin
                // Recovered slot becomes the working copy, younger ones die
                version_head_q <= recover_checkpoint_i;
                live_q         <= ckpt_cnt_t'(checkpoint_ptr_t'(recover_checkpoint_i - vtail_n));
            end else begin
                live_q <= live_q + ckpt_cnt_t'(ckpt_en) - ckpt_cnt_t'(delete_checkpoint_i);
                if (ckpt_en) begin
                    checkpoint_o   <= version_head_q; // Old slot keeps the snapshot
                    version_head_q <= version_next;
                end
                for (int c = 0; c < `NUM_CHECKPOINTS; c++) begin
                    if (checkpoint_ptr_t'(c) == version_head_q ||
                        (ckpt_en && checkpoint_ptr_t'(c) == version_next)) begin
                        head_q[c]  <= head_n;
                        tail_q[c]  <= tail_n;
                        count_q[c] <= count_n;
                    end else if (push && count_q[c] < fl_cnt_t'(`NUM_FREE_ENTRIES)) begin
                        tail_q[c]  <= tail_q[c] + 1'b1;  // Older copies see the free too
                        count_q[c] <= count_q[c] + 1'b1;
                    end
                end
            end
        end
    end

    // Register table, reset loads 32..63 in order
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int c = 0; c < `NUM_CHECKPOINTS; c++) begin
                for (int e = 0; e < `NUM_FREE_ENTRIES; e++) begin
                    fl_table[c][e] <= phreg_t'(`NUM_ISA_REGS + e);
                end
            end
        end else begin
            for (int c = 0; c < `NUM_CHECKPOINTS; c++) begin
                if (ckpt_en && checkpoint_ptr_t'(c) == version_next) begin
                    // Full copy of the working table with this cycle's push
                    for (int e = 0; e < `NUM_FREE_ENTRIES; e++) begin
                        if (work_write && fl_idx_t'(e) == tail_q[version_head_q])
                            fl_table[c][e] <= free_preg_i;
                        else
                            fl_table[c][e] <= fl_table[version_head_q][e];
                    end
                end else if (checkpoint_ptr_t'(c) == version_head_q) begin
                    if (work_write)
                        fl_table[c][tail_q[c]] <= free_preg_i;
                end else if (push && count_q[c] < fl_cnt_t'(`NUM_FREE_ENTRIES)) begin
                    fl_table[c][tail_q[c]] <= free_preg_i;
                end
            end
        end
    end

    // Popped register, held between pops
    always_ff @(posedge clk_i) begin
        if (pop)
            new_preg_o <= head_preg_o;
    end

endmodule

//--- source/rename_pkg.sv
/* Types shared by the rename stage. Widths follow rename_consts.svh. */
`include "rename_consts.svh"

package rename_pkg;

    // Register numbers
    typedef logic [$clog2(`NUM_PHYS_REGS)-1:0]   phreg_t;          // Physical register
    typedef logic [$clog2(`NUM_ISA_REGS)-1:0]    areg_t;           // Architectural register
    typedef logic [$clog2(`NUM_CHECKPOINTS)-1:0] checkpoint_ptr_t; // Checkpoint label

    // One decoded instruction as seen by rename
    typedef struct packed {
        areg_t src1;
        areg_t src2;
        areg_t dst;       // 0 means no destination
        logic  is_branch; // Takes a checkpoint
    } rename_req_t;

    // Renamed instruction toward dispatch
    typedef struct packed {
        phreg_t          psrc1;
        phreg_t          psrc2;
        phreg_t          pdst;           // 0 when dst is x0
        phreg_t          old_pdst;       // Freed by commit later
        logic            has_checkpoint;
        checkpoint_ptr_t checkpoint;     // Label for a later recover
    } rename_rsp_t;

    // Register release from commit
    typedef struct packed {
        logic   free_valid;
        phreg_t free_preg;
    } commit_t;

endpackage

//--- source/rename_table.sv
/* Map table with one copy per checkpoint slot. The version pointer follows the
   free list by counting the same checkpoint and recover events. x0 is never written. */
`timescale 1ns/10ps
`include "rename_consts.svh"

module rename_table (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        rename_i,             // Request accepted this cycle
    input  rename_pkg::rename_req_t     req_i,
    input  rename_pkg::phreg_t          new_preg_i,           // Free list head, combinational
    input  logic                        do_checkpoint_i,
    input  logic                        do_recover_i,
    input  rename_pkg::checkpoint_ptr_t recover_checkpoint_i,
    output rename_pkg::phreg_t          psrc1_o,              // Registered lookups
    output rename_pkg::phreg_t          psrc2_o,
    output rename_pkg::phreg_t          old_pdst_o
);
    import rename_pkg::*;

    // One map per checkpoint slot
    phreg_t map_q [`NUM_CHECKPOINTS][`NUM_ISA_REGS];

    checkpoint_ptr_t version_q;    // Working map
    checkpoint_ptr_t version_next; // Slot a checkpoint copies into
    logic            write_en;     // Destination mapping changes

    assign version_next = version_q + 1'b1;
    assign write_en     = rename_i & (req_i.dst != '0);

    // Version pointer, same stepping as the free list
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            version_q <= '0;
        end else if (do_recover_i) begin
            version_q <= recover_checkpoint_i; // Back to the branch's snapshot
        end else if (do_checkpoint_i) begin
            version_q <= version_next;
        end
    end

    // Map storage, identity after reset
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int c = 0; c < `NUM_CHECKPOINTS; c++) begin
                for (int a = 0; a < `NUM_ISA_REGS; a++) begin
                    map_q[c][a] <= phreg_t'(a);
                end
            end
        end else if (!do_recover_i) begin
            for (int c = 0; c < `NUM_CHECKPOINTS; c++) begin
                // Working slot takes the update, the checkpoint slot a copy of it
                if (checkpoint_ptr_t'(c) == version_q ||
                    (do_checkpoint_i && checkpoint_ptr_t'(c) == version_next)) begin
                    for (int a = 0; a < `NUM_ISA_REGS; a++) begin
                        if (write_en && areg_t'(a) == req_i.dst)
                            map_q[c][a] <= new_preg_i;
                        else
                            map_q[c][a] <= map_q[version_q][a];
                    end
                end
            end
        end
    end

    // Lookups see the map before this instruction's own write
    always_ff @(posedge clk_i) begin
        if (rename_i) begin
            psrc1_o    <= map_q[version_q][req_i.src1];
            psrc2_o    <= map_q[version_q][req_i.src2];
            old_pdst_o <= map_q[version_q][req_i.dst]; // x0 reads preg 0
        end
    end

endmodule

//--- source/rename_unit.sv
/* Single-issue rename stage. Response comes one cycle after acceptance.
   Commit must not free in a recover cycle, the free would be dropped. */
`timescale 1ns/10ps
`include "rename_consts.svh"

module rename_unit (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    // Decode
    input  logic                        req_valid_i,
    input  rename_pkg::rename_req_t     req_i,
    output logic                        stall_o,
    // Dispatch
    output logic                        rsp_valid_o,
    output rename_pkg::rename_rsp_t     rsp_o,
    input  logic                        credit_i,             // One slot freed
    // Commit
    input  rename_pkg::commit_t         commit_i,
    // Branch
    input  logic                        recover_i,
    input  logic                        delete_checkpoint_i,
    input  rename_pkg::checkpoint_ptr_t recover_checkpoint_i
);
    import rename_pkg::*;

    typedef logic [$clog2(`NUM_DISPATCH_CREDITS + 1)-1:0] credit_cnt_t;

    credit_cnt_t     credits_q;      // Free dispatch slots
    logic            accept;
    logic            dst_nonzero;
    logic            take_checkpoint;
    logic            fl_empty;
    logic            fl_out_of_ckpt;
    phreg_t          new_preg;       // Registered pop
    phreg_t          head_preg;      // Head now, for the map write
    phreg_t          psrc1;
    phreg_t          psrc2;
    phreg_t          old_pdst;
    checkpoint_ptr_t ckpt_label;
    logic            branch_q;
    logic            dst_zero_q;

    assign dst_nonzero     = (req_i.dst != '0);
    assign stall_o         = (credits_q == '0) | (fl_empty & dst_nonzero)
                             | (req_i.is_branch & fl_out_of_ckpt) | recover_i;
    assign accept          = req_valid_i & ~stall_o;
    assign take_checkpoint = accept & req_i.is_branch; // Snapshot after the branch renames

    // Dispatch credits, never above the reset value
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            credits_q <= credit_cnt_t'(`NUM_DISPATCH_CREDITS);
        end else if (accept && !credit_i) begin
            credits_q <= credits_q - 1'b1;
        end else if (!accept && credit_i &&
                     credits_q < credit_cnt_t'(`NUM_DISPATCH_CREDITS)) begin
            credits_q <= credits_q + 1'b1;
        end
    end

    free_list u_free_list (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .alloc_i              (accept & dst_nonzero), // x0 never allocates
        .free_i               (commit_i.free_valid),
        .free_preg_i          (commit_i.free_preg),
        .do_checkpoint_i      (take_checkpoint),
        .do_recover_i         (recover_i),
        .delete_checkpoint_i  (delete_checkpoint_i),
        .recover_checkpoint_i (recover_checkpoint_i),
        .new_preg_o           (new_preg),
        .head_preg_o          (head_preg),
        .checkpoint_o         (ckpt_label),
        .out_of_checkpoints_o (fl_out_of_ckpt),
        .empty_o              (fl_empty)
    );

    rename_table u_rename_table (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .rename_i             (accept),
        .req_i                (req_i),
        .new_preg_i           (head_preg),
        .do_checkpoint_i      (take_checkpoint),
        .do_recover_i         (recover_i),
        .recover_checkpoint_i (recover_checkpoint_i),
        .psrc1_o              (psrc1),
        .psrc2_o              (psrc2),
        .old_pdst_o           (old_pdst)
    );

    // Response control, one cycle behind acceptance
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rsp_valid_o <= 1'b0;
            branch_q    <= 1'b0;
        end else begin
            rsp_valid_o <= accept;
            branch_q    <= take_checkpoint;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept)
            dst_zero_q <= ~dst_nonzero;
    end

    always_comb begin
        rsp_o.psrc1          = psrc1;
        rsp_o.psrc2          = psrc2;
        rsp_o.pdst           = dst_zero_q ? '0 : new_preg; // new_preg is stale for x0
        rsp_o.old_pdst       = old_pdst;
        rsp_o.has_checkpoint = branch_q;
        rsp_o.checkpoint     = ckpt_label;
    end

endmodule

//--- verif/tb_rename_unit.sv
/* Table-driven testbench with a reference model of map, free FIFO and checkpoints.
   Commit frees are never issued in a recover cycle. */
`timescale 1ns/10ps
`include "rename_consts.svh"

module tb_rename_unit;
    import rename_pkg::*;

    localparam int K_REQ = 0, K_CRED = 1, K_COMMIT = 2, K_RECOVER = 3, K_DELETE = 4, K_FILL = 5;
    localparam int RSP_TIMEOUT = 8;  // Cycles to wait for rsp_valid_o

    typedef struct packed {
        logic [2:0] kind;
        areg_t      src1;
        areg_t      src2;
        areg_t      dst;
        logic       br;
        logic       ret;    // Return the credit in the response cycle
        logic [7:0] arg;    // Freed preg, label or filler count
    } step_t;

    logic clk_i, rstn_i, req_valid_i, stall_o, rsp_valid_o, credit_i;
    logic recover_i, delete_checkpoint_i;
    rename_req_t req_i;
    rename_rsp_t rsp_o;
    commit_t commit_i;
    checkpoint_ptr_t recover_checkpoint_i;

    step_t steps[$];
    int    seed = 32'h1ed84bdc;

    // Reference model
    phreg_t          map_m [`NUM_ISA_REGS];
    phreg_t          fl_m[$];
    phreg_t          ck_map [`NUM_CHECKPOINTS][`NUM_ISA_REGS];
    phreg_t          ck_fl [`NUM_CHECKPOINTS][$];
    checkpoint_ptr_t vhead = '0, vtail = '0, last_label = '0;
    int              live = 0;
    int              credits = `NUM_DISPATCH_CREDITS;

    rename_unit uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;  // 40 ns period
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_rsp(input rename_rsp_t got, input rename_rsp_t exp, input string name);
        if (got !== exp)
            fail_now($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_preg(input phreg_t got, input phreg_t exp, input string name);
        if (got !== exp)
            fail_now($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp)
            fail_now($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    endtask

    function automatic void add_step(input int kind, input int s1, input int s2, input int d,
                                     input bit br, input bit ret, input int arg);
        step_t s;
        s = '{kind[2:0], areg_t'(s1), areg_t'(s2), areg_t'(d), br, ret, arg[7:0]};
        steps.push_back(s);
    endfunction

    // Commit frees reach every copy that still has room
    function automatic void push_free(input phreg_t p);
        if (fl_m.size() < `NUM_FREE_ENTRIES)
            fl_m.push_back(p);
        for (int c = 0; c < `NUM_CHECKPOINTS; c++)
            if (ck_fl[c].size() < `NUM_FREE_ENTRIES)
                ck_fl[c].push_back(p);
    endfunction

    task automatic do_request(input rename_req_t r, input bit ret);
        rename_rsp_t exp;
        logic        exp_stall;
        int          n;
        @(negedge clk_i);
        credit_i    = 1'b0;
        req_valid_i = 1'b1;
        req_i       = r;
        exp_stall = (credits == 0) || (fl_m.size() == 0 && r.dst != '0) ||
                    (r.is_branch && live == `NUM_CHECKPOINTS - 1);
        #10;
        check_bit(stall_o, exp_stall, "stall_o");
        if (exp_stall) begin
            check_bit(rsp_valid_o, 1'b0, "rsp_valid_o");
            @(negedge clk_i);
            req_valid_i = 1'b0;
            check_bit(rsp_valid_o, 1'b0, "rsp_valid_o");  // Nothing accepted
            return;
        end
        // Sources and old destination read before the destination write
        exp.psrc1    = map_m[r.src1];
        exp.psrc2    = map_m[r.src2];
        exp.old_pdst = map_m[r.dst];
        exp.pdst     = '0;
        if (r.dst != '0) begin
            exp.pdst = fl_m.pop_front();
            map_m[r.dst] = exp.pdst;
        end
        if (r.is_branch) begin
            ck_map[vhead] = map_m;  // Snapshot after the branch itself
            ck_fl[vhead]  = fl_m;
            last_label    = vhead;
            vhead++;
            live++;
        end
        exp.has_checkpoint = r.is_branch;
        exp.checkpoint     = last_label;
        credits--;
        @(negedge clk_i);
        req_valid_i = 1'b0;
        if (ret) begin
            credit_i = 1'b1;
            credits++;
        end
        n = 0;
        while (!rsp_valid_o && n < RSP_TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (!rsp_valid_o)
            fail_now("Timeout, no response from the DUT after an accepted request");
        if (n != 0)
            fail_now($sformatf("Response came %0d cycles later than one cycle after acceptance",
                               n));
        check_preg(rsp_o.pdst, exp.pdst, "rsp_o.pdst");
        check_rsp(rsp_o, exp, "rsp_o");
    endtask

    task automatic apply_step(input step_t s);
        rename_req_t r;
        @(negedge clk_i);
        credit_i = 1'b0;
        check_bit(rsp_valid_o, 1'b0, "rsp_valid_o");  // Response lasts one cycle only
        case (s.kind)
            K_REQ: begin
                r = '{s.src1, s.src2, s.dst, s.br};
                do_request(r, s.ret);
            end
            K_CRED: begin
                credit_i = 1'b1;
                if (credits < `NUM_DISPATCH_CREDITS)
                    credits++;
            end
            K_COMMIT: begin
                commit_i = '{1'b1, phreg_t'(s.arg)};
                push_free(phreg_t'(s.arg));
                @(negedge clk_i);
                commit_i = '0;
            end
            K_RECOVER: begin
                recover_i            = 1'b1;
                recover_checkpoint_i = checkpoint_ptr_t'(s.arg);
                #10;
                check_bit(stall_o, 1'b1, "stall_o");
                map_m = ck_map[s.arg[1:0]];
                fl_m  = ck_fl[s.arg[1:0]];
                vhead = s.arg[1:0];
                live  = int'(checkpoint_ptr_t'(vhead - vtail));
                @(negedge clk_i);
                recover_i = 1'b0;
            end
            K_DELETE: begin
                delete_checkpoint_i = 1'b1;
                vtail++;
                live--;
                @(negedge clk_i);
                delete_checkpoint_i = 1'b0;
            end
            default: begin
                // Filler renames with random registers and a nonzero destination
                for (int i = 0; i < s.arg; i++) begin
                    r.src1 = areg_t'($random(seed));
                    r.src2 = areg_t'($random(seed));
                    r.dst  = areg_t'(1 + ({$random(seed)} % 31));
                    r.is_branch = 1'b0;
                    do_request(r, 1'b1);
                end
            end
        endcase
    endtask

    initial begin
        req_valid_i = 1'b0;
        req_i = '0;
        credit_i = 1'b0;
        commit_i = '0;
        recover_i = 1'b0;
        delete_checkpoint_i = 1'b0;
        recover_checkpoint_i = '0;
        for (int a = 0; a < `NUM_ISA_REGS; a++)
            map_m[a] = phreg_t'(a);
        for (int e = 0; e < `NUM_FREE_ENTRIES; e++)
            fl_m.push_back(phreg_t'(`NUM_ISA_REGS + e));

        add_step(K_REQ, 1, 2, 3, 0, 1, 0);      // Identity sources and pdst 32
        add_step(K_REQ, 4, 5, 6, 0, 1, 0);
        add_step(K_REQ, 7, 8, 9, 0, 1, 0);
        add_step(K_REQ, 3, 6, 10, 0, 1, 0);     // Reads fresh mappings
        add_step(K_REQ, 1, 2, 0, 0, 1, 0);      // x0 allocates nothing
        add_step(K_REQ, 1, 2, 11, 0, 1, 0);
        add_step(K_REQ, 11, 3, 0, 1, 1, 0);     // Branch with label 0
        add_step(K_REQ, 11, 12, 11, 0, 1, 0);
        add_step(K_REQ, 5, 5, 5, 0, 1, 0);
        add_step(K_RECOVER, 0, 0, 0, 0, 0, 0);
        add_step(K_REQ, 11, 5, 12, 0, 1, 0);    // Mappings and head as after the branch
        add_step(K_REQ, 1, 2, 13, 1, 1, 0);     // Three live checkpoints
        add_step(K_REQ, 13, 2, 14, 1, 1, 0);
        add_step(K_REQ, 14, 13, 15, 1, 1, 0);
        add_step(K_REQ, 15, 1, 16, 1, 1, 0);    // Out of checkpoints
        add_step(K_DELETE, 0, 0, 0, 0, 0, 0);
        add_step(K_REQ, 15, 1, 16, 1, 1, 0);    // Released
        add_step(K_RECOVER, 0, 0, 0, 0, 0, 2);
        add_step(K_REQ, 16, 15, 17, 0, 1, 0);
        for (int i = 0; i < 4; i++)
            add_step(K_REQ, i, i + 1, 18 + i, 0, 0, 0);  // Spend all credits
        add_step(K_REQ, 1, 1, 22, 0, 1, 0);     // Stalls on credits
        add_step(K_CRED, 0, 0, 0, 0, 0, 0);
        add_step(K_REQ, 1, 1, 22, 0, 0, 0);     // Exactly one more
        add_step(K_REQ, 2, 2, 23, 0, 1, 0);     // Stalls again
        for (int i = 0; i < 4; i++)
            add_step(K_CRED, 0, 0, 0, 0, 0, 0);
        add_step(K_FILL, 0, 0, 0, 0, 0, 40);    // Drain the free list
        add_step(K_REQ, 3, 4, 0, 0, 1, 0);      // x0 passes while empty
        add_step(K_COMMIT, 0, 0, 0, 0, 0, 7);
        add_step(K_COMMIT, 0, 0, 0, 0, 0, 9);
        add_step(K_REQ, 5, 6, 24, 0, 1, 0);     // FIFO order gives 7 then 9
        add_step(K_REQ, 24, 6, 25, 0, 1, 0);
        add_step(K_REQ, 1, 2, 26, 0, 1, 0);     // Empty again
        add_step(K_COMMIT, 0, 0, 0, 0, 0, 50);
        add_step(K_REQ, 26, 25, 26, 0, 1, 0);   // Gets 50

        rstn_i = 1'b0;
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;
        #10;
        check_bit(stall_o, 1'b0, "stall_o");
        check_bit(rsp_valid_o, 1'b0, "rsp_valid_o");

        foreach (steps[i])
            apply_step(steps[i]);
        @(negedge clk_i);

        $display("Everything OK");
        $finish;
    end

endmodule
